// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing
TOP       = fp_alu_tb
FILELIST  = fp_alu.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@if ./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== fp_alu.f ====
+incdir+test
source/fpu_pkg.sv
source/fp_add_unit.sv
source/fp_mul_unit.sv
source/fp_result_stage.sv
source/fp_alu.sv
test/fp_alu_tb.sv

// ==== source/fp_add_unit.sv ====
`timescale 1ns/1ps

module fp_add_unit (
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    input  fpu_pkg::fp_op_t   op,
    output fpu_pkg::fp_word_t sum,
    output logic              invalid,
    output logic              inexact,
    output logic              overflow,
    output logic              underflow
);

    logic                                                b_sign;   // b sign after the SUB flip
    logic                                                eff_sub;
    logic                                                a_zero;
    logic                                                b_zero;
    logic                                                a_inf;
    logic                                                b_inf;
    logic [fpu_pkg::FP_EXP_W+fpu_pkg::FP_FRAC_W-1:0]     a_mag;
    logic [fpu_pkg::FP_EXP_W+fpu_pkg::FP_FRAC_W-1:0]     b_mag;
    logic                                                a_big;
    logic                                                big_sign;
    logic [fpu_pkg::FP_EXP_W-1:0]                        big_exp;
    logic [fpu_pkg::FP_EXP_W-1:0]                        small_exp;
    logic [fpu_pkg::FP_SIG_W-1:0]                        big_sig;
    logic [fpu_pkg::FP_SIG_W-1:0]                        small_sig;
    logic [fpu_pkg::FP_EXP_W-1:0]                        exp_diff;
    logic [4:0]                                          shamt;
    logic [fpu_pkg::FP_ALIGN_W-1:0]                      small_wide;
    logic [fpu_pkg::FP_EXT_W-1:0]                        big_ext;
    logic [fpu_pkg::FP_EXT_W-1:0]                        small_ext;
    logic [fpu_pkg::FP_SUM_W-1:0]                        mag;
    logic [4:0]                                          lead;
    logic [4:0]                                          lz;
    logic [fpu_pkg::FP_SUM_W-1:0]                        norm;
    logic signed [9:0]                                   exp_res;

    // ====================
    // unpack and order
    // ====================

    assign b_sign  = b[31] ^ (op == fpu_pkg::SUB);
    assign eff_sub = a[31] ^ b_sign;

    assign a_zero = (a[30:23] == '0);   // subnormals count as zero
    assign b_zero = (b[30:23] == '0);
    assign a_inf  = (a[30:23] == fpu_pkg::FP_EXP_MAX);
    assign b_inf  = (b[30:23] == fpu_pkg::FP_EXP_MAX);

    assign a_mag = a_zero ? '0 : a[30:0];
    assign b_mag = b_zero ? '0 : b[30:0];
    assign a_big = (a_mag >= b_mag);

    assign big_sign  = a_big ? a[31] : b_sign;
    assign big_exp   = a_big ? a_mag[30:23] : b_mag[30:23];
    assign small_exp = a_big ? b_mag[30:23] : a_mag[30:23];
    assign big_sig   = a_big ? {~a_zero, a_mag[22:0]} : {~b_zero, b_mag[22:0]};
    assign small_sig = a_big ? {~b_zero, b_mag[22:0]} : {~a_zero, a_mag[22:0]};

    // ====================
    // align
    // ====================

    // beyond the window every bit of the smaller operand lands in sticky
    assign exp_diff = big_exp - small_exp;
    assign shamt    = (exp_diff > 8'(fpu_pkg::FP_EXT_W - 1)) ? 5'(fpu_pkg::FP_EXT_W - 1)
                                                              : exp_diff[4:0];

    assign small_wide = {small_sig, {(fpu_pkg::FP_EXT_W - 1){1'b0}}} >> shamt;
    assign small_ext  = {small_wide[fpu_pkg::FP_ALIGN_W-1 -: fpu_pkg::FP_EXT_W-1],
                         |small_wide[fpu_pkg::FP_SIG_W-1:0]};
    assign big_ext    = {big_sig, {fpu_pkg::FP_GRS_W{1'b0}}};

    // big is never below small, so the difference stays positive
    assign mag = eff_sub ? {1'b0, big_ext} - {1'b0, small_ext}
                         : {1'b0, big_ext} + {1'b0, small_ext};

    // ====================
    // normalize
    // ====================

    always_comb begin
        lead = '0;
        for (int i = 0; i < fpu_pkg::FP_SUM_W; i++) begin
            if (mag[i]) begin
                lead = 5'(i);   // highest set bit wins
            end
        end
    end

    assign lz   = 5'(fpu_pkg::FP_SUM_W - 1) - lead;
    assign norm = mag << lz;

    // hidden bit of big_ext sits one place below the top of mag
    assign exp_res = $signed({2'b00, big_exp}) + 10'sd1 - $signed({5'b00000, lz});

    always_comb begin
        sum       = '0;
        invalid   = 1'b0;
        inexact   = 1'b0;
        overflow  = 1'b0;
        underflow = 1'b0;
        if (a_inf && b_inf && eff_sub) begin
            sum     = fpu_pkg::FP_QNAN;
            invalid = 1'b1;
        end else if (a_inf) begin
            sum = a[31] ? fpu_pkg::FP_NEG_INF : fpu_pkg::FP_POS_INF;
        end else if (b_inf) begin
            sum = b_sign ? fpu_pkg::FP_NEG_INF : fpu_pkg::FP_POS_INF;
        end else if (mag == '0) begin
            sum = '0;   // exact cancellation gives +0
        end else if (exp_res > 10'sd254) begin
            sum      = big_sign ? fpu_pkg::FP_NEG_INF : fpu_pkg::FP_POS_INF;
            overflow = 1'b1;
            inexact  = 1'b1;
        end else if (exp_res < 10'sd1) begin
            underflow = 1'b1;
            inexact   = 1'b1;
        end else begin
            sum     = {big_sign, exp_res[7:0], norm[fpu_pkg::FP_SUM_W-2 -: fpu_pkg::FP_FRAC_W]};
            inexact = |norm[fpu_pkg::FP_GRS_W:0];   // truncated low bits
        end
    end

endmodule

// ==== source/fp_alu.sv ====
`timescale 1ns/1ps

module fp_alu (
    input  logic              clk,
    input  logic              arst_n,
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    input  fpu_pkg::fp_op_t   op,
    output fpu_pkg::fp_word_t result,
    output logic              invalid,
    output logic              inexact,
    output logic              overflow,
    output logic              underflow
);

    fpu_pkg::fp_word_t sum;
    fpu_pkg::fp_word_t product;
    logic              add_invalid;
    logic              add_inexact;
    logic              add_overflow;
    logic              add_underflow;
    logic              mul_invalid;
    logic              mul_inexact;
    logic              mul_overflow;
    logic              mul_underflow;

    // ====================
    // arithmetic
    // ====================

    fp_add_unit u_add (
        .a         (a),
        .b         (b),
        .op        (op),
        .sum       (sum),
        .invalid   (add_invalid),
        .inexact   (add_inexact),
        .overflow  (add_overflow),
        .underflow (add_underflow)
    );

    fp_mul_unit u_mul (
        .a         (a),
        .b         (b),
        .product   (product),
        .invalid   (mul_invalid),
        .inexact   (mul_inexact),
        .overflow  (mul_overflow),
        .underflow (mul_underflow)
    );

    // results show up the cycle after the operands
    fp_result_stage u_result (
        .clk           (clk),
        .arst_n        (arst_n),
        .a             (a),
        .b             (b),
        .op            (op),
        .sum           (sum),
        .product       (product),
        .add_invalid   (add_invalid),
        .add_inexact   (add_inexact),
        .add_overflow  (add_overflow),
        .add_underflow (add_underflow),
        .mul_invalid   (mul_invalid),
        .mul_inexact   (mul_inexact),
        .mul_overflow  (mul_overflow),
        .mul_underflow (mul_underflow),
        .result        (result),
        .invalid       (invalid),
        .inexact       (inexact),
        .overflow      (overflow),
        .underflow     (underflow)
    );

endmodule

// ==== source/fp_mul_unit.sv ====
`timescale 1ns/1ps

module fp_mul_unit (
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    output fpu_pkg::fp_word_t product,
    output logic              invalid,
    output logic              inexact,
    output logic              overflow,
    output logic              underflow
);

    logic                           p_sign;
    logic                           a_zero;
    logic                           b_zero;
    logic                           a_inf;
    logic                           b_inf;
    logic [fpu_pkg::FP_SIG_W-1:0]   a_sig;
    logic [fpu_pkg::FP_SIG_W-1:0]   b_sig;
    logic [fpu_pkg::FP_PROD_W-1:0]  prod;
    logic signed [9:0]              exp_sum;
    logic signed [9:0]              exp_res;
    logic [fpu_pkg::FP_FRAC_W-1:0]  frac_res;
    logic                           lost;

    // ====================
    // operands
    // ====================

    assign p_sign = a[31] ^ b[31];

    assign a_zero = (a[30:23] == '0);   // subnormal inputs act as zeros
    assign b_zero = (b[30:23] == '0);
    assign a_inf  = (a[30:23] == fpu_pkg::FP_EXP_MAX);
    assign b_inf  = (b[30:23] == fpu_pkg::FP_EXP_MAX);

    assign a_sig = {1'b1, a[22:0]};
    assign b_sig = {1'b1, b[22:0]};

    assign prod    = a_sig * b_sig;
    assign exp_sum = $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]})
                   - 10'(fpu_pkg::FP_BIAS);

    // ====================
    // normalize
    // ====================

    // the product of two values in [1,2) needs at most one right step
    always_comb begin
        if (prod[fpu_pkg::FP_PROD_W-1]) begin
            exp_res  = exp_sum + 10'sd1;
            frac_res = prod[46:24];
            lost     = |prod[23:0];
        end else begin
            exp_res  = exp_sum;
            frac_res = prod[45:23];
            lost     = |prod[22:0];
        end
    end

    always_comb begin
        product   = '0;
        invalid   = 1'b0;
        inexact   = 1'b0;
        overflow  = 1'b0;
        underflow = 1'b0;
        if ((a_inf && b_zero) || (b_inf && a_zero)) begin
            product = fpu_pkg::FP_QNAN;
            invalid = 1'b1;
        end else if (a_inf || b_inf) begin
            product = p_sign ? fpu_pkg::FP_NEG_INF : fpu_pkg::FP_POS_INF;
        end else if (a_zero || b_zero) begin
            product = '0;   // zero products come out as +0
        end else if (exp_res > 10'sd254) begin
            product  = p_sign ? fpu_pkg::FP_NEG_INF : fpu_pkg::FP_POS_INF;
            overflow = 1'b1;
            inexact  = 1'b1;
        end else if (exp_res < 10'sd1) begin
            underflow = 1'b1;
            inexact   = 1'b1;
        end else begin
            product = {p_sign, exp_res[7:0], frac_res};
            inexact = lost;
        end
    end

endmodule

// ==== source/fp_result_stage.sv ====
`timescale 1ns/1ps

module fp_result_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    input  fpu_pkg::fp_op_t   op,
    input  fpu_pkg::fp_word_t sum,
    input  fpu_pkg::fp_word_t product,
    input  logic              add_invalid,
    input  logic              add_inexact,
    input  logic              add_overflow,
    input  logic              add_underflow,
    input  logic              mul_invalid,
    input  logic              mul_inexact,
    input  logic              mul_overflow,
    input  logic              mul_underflow,
    output fpu_pkg::fp_word_t result,
    output logic              invalid,
    output logic              inexact,
    output logic              overflow,
    output logic              underflow
);

    logic                                             any_nan;
    logic                                             a_zero;
    logic                                             b_zero;
    logic                                             a_neg;
    logic                                             b_neg;
    logic [fpu_pkg::FP_EXP_W+fpu_pkg::FP_FRAC_W-1:0]  a_mag;
    logic [fpu_pkg::FP_EXP_W+fpu_pkg::FP_FRAC_W-1:0]  b_mag;
    logic                                             lt;
    fpu_pkg::fp_word_t                                result_d;
    logic [3:0]                                       flags_d;   // invalid, inexact, ovf, unf

    assign any_nan = ((a[30:23] == fpu_pkg::FP_EXP_MAX) && (a[22:0] != '0))
                  || ((b[30:23] == fpu_pkg::FP_EXP_MAX) && (b[22:0] != '0));

    // ====================
    // compare
    // ====================

    assign a_zero = (a[30:23] == '0);
    assign b_zero = (b[30:23] == '0);
    assign a_neg  = a[31] & ~a_zero;   // -0 orders like +0
    assign b_neg  = b[31] & ~b_zero;
    assign a_mag  = a_zero ? '0 : a[30:0];
    assign b_mag  = b_zero ? '0 : b[30:0];

    always_comb begin
        if (a_neg != b_neg) begin
            lt = a_neg;
        end else if (a_mag[30:23] != b_mag[30:23]) begin
            lt = a_neg ? (a_mag[30:23] > b_mag[30:23]) : (a_mag[30:23] < b_mag[30:23]);
        end else begin
            lt = a_neg ? (a_mag[22:0] > b_mag[22:0]) : (a_mag[22:0] < b_mag[22:0]);
        end
    end

    // ====================
    // select and register
    // ====================

    always_comb begin
        result_d = '0;
        flags_d  = '0;
        case (op)
            fpu_pkg::ADD, fpu_pkg::SUB: begin
                result_d = any_nan ? fpu_pkg::FP_QNAN : sum;
                flags_d  = any_nan ? 4'b1000
                                   : {add_invalid, add_inexact, add_overflow, add_underflow};
            end
            fpu_pkg::MUL: begin
                result_d = any_nan ? fpu_pkg::FP_QNAN : product;
                flags_d  = any_nan ? 4'b1000
                                   : {mul_invalid, mul_inexact, mul_overflow, mul_underflow};
            end
            fpu_pkg::NOP: result_d = a;   // passes NaNs untouched
            fpu_pkg::SLT: begin
                result_d = {31'd0, lt & ~any_nan};   // integer 1, not 1.0
                flags_d  = {any_nan, 3'b000};
            end
            default: result_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result                                  <= '0;
            {invalid, inexact, overflow, underflow} <= '0;
        end else begin
            result                                  <= result_d;
            {invalid, inexact, overflow, underflow} <= flags_d;
        end
    end

endmodule

// ==== source/fpu_pkg.sv ====
package fpu_pkg;

    // ====================
    // word format
    // ====================

    localparam int FP_WORD_W = 32;
    localparam int FP_EXP_W  = 8;
    localparam int FP_FRAC_W = 23;
    localparam int FP_SIG_W  = FP_FRAC_W + 1;      // hidden bit included
    localparam int FP_BIAS   = 127;

    localparam logic [FP_EXP_W-1:0] FP_EXP_MAX = '1;   // infinity and NaN exponent

    typedef logic [FP_WORD_W-1:0] fp_word_t;

    // ====================
    // datapath widths
    // ====================

    // the adder keeps guard, round and sticky below the significand
    localparam int FP_GRS_W   = 3;
    localparam int FP_EXT_W   = FP_SIG_W + FP_GRS_W;
    localparam int FP_SUM_W   = FP_EXT_W + 1;            // room for the carry out
    localparam int FP_ALIGN_W = FP_SIG_W + FP_EXT_W - 1;  // shifter window before sticky fold
    localparam int FP_PROD_W  = 2 * FP_SIG_W;

    // ====================
    // special encodings
    // ====================

    localparam fp_word_t FP_QNAN    = {1'b0, FP_EXP_MAX, 1'b1, {(FP_FRAC_W - 1){1'b0}}};
    localparam fp_word_t FP_POS_INF = {1'b0, FP_EXP_MAX, {FP_FRAC_W{1'b0}}};
    localparam fp_word_t FP_NEG_INF = {1'b1, FP_EXP_MAX, {FP_FRAC_W{1'b0}}};

    // codes 19 to 21 are unused
    typedef enum logic [4:0] {
        ADD = 5'd16,
        SUB = 5'd17,
        MUL = 5'd18,
        NOP = 5'd22,
        SLT = 5'd23
    } fp_op_t;

endpackage

// ==== test/fp_alu_checks.svh ====
`ifndef FP_ALU_CHECKS_SVH
`define FP_ALU_CHECKS_SVH

// ====================
// error counters
// ====================

int word_errors = 0;
int flag_errors = 0;

// a flag set is packed as {invalid, inexact, overflow, underflow}

task automatic check_word(
    input fpu_pkg::fp_word_t got,
    input fpu_pkg::fp_word_t expected,
    input string             what
);
    if (got !== expected) begin
        $display("ERR %0t: %s result %08h, expected %08h", $time, what, got, expected);
        word_errors++;
    end
endtask

task automatic check_flags(
    input logic [3:0] got,
    input logic [3:0] expected,
    input string      what
);
    if (got !== expected) begin
        // bit order in the printout is invalid, inexact, overflow, underflow
        $display("ERR %0t: %s flags %04b, expected %04b", $time, what, got, expected);
        flag_errors++;
    end
endtask

function automatic int total_errors();
    return word_errors + flag_errors;
endfunction

`endif

// ==== test/fp_alu_tb.sv ====
`timescale 1ns/1ps

module fp_alu_tb;

    logic              clk;
    logic              arst_n;
    fpu_pkg::fp_word_t a;
    fpu_pkg::fp_word_t b;
    fpu_pkg::fp_op_t   op;
    fpu_pkg::fp_word_t result;
    logic              invalid;
    logic              inexact;
    logic              overflow;
    logic              underflow;
    logic [3:0]        flags;
    bit                reset_ok;

    `include "fp_alu_checks.svh"

    assign flags = {invalid, inexact, overflow, underflow};

    fp_alu DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .a         (a),
        .b         (b),
        .op        (op),
        .result    (result),
        .invalid   (invalid),
        .inexact   (inexact),
        .overflow  (overflow),
        .underflow (underflow)
    );

    always #5 clk = ~clk;

    // ====================
    // reference helpers
    // ====================

    // only for values that single precision holds exactly in its normal range
    function automatic fpu_pkg::fp_word_t to_word(input real r);
        logic [63:0] d;
        logic [10:0] e;
        d = $realtobits(r);
        e = d[62:52] - 11'd896;   // rebias from 1023 to 127
        if (r == 0.0) begin
            return '0;
        end
        return {d[63], e[7:0], d[51:29]};
    endfunction

    function automatic int rand_int(input int span);
        return int'($urandom_range(2 * span)) - span;
    endfunction

    // integer operands keep every result exact, so no flag is ever expected
    function automatic fpu_pkg::fp_word_t int_op_word(input fpu_pkg::fp_op_t code,
                                                      input int x, input int y);
        case (code)
            fpu_pkg::ADD: return to_word(real'(x + y));
            fpu_pkg::SUB: return to_word(real'(x - y));
            fpu_pkg::MUL: return to_word(real'(x * y));
            fpu_pkg::SLT: return {31'd0, x < y};
            fpu_pkg::NOP: return to_word(real'(x));
            default:      return '0;
        endcase
    endfunction

    task automatic exec_op(input fpu_pkg::fp_word_t a_v, input fpu_pkg::fp_word_t b_v,
                           input fpu_pkg::fp_op_t op_v, input fpu_pkg::fp_word_t exp_word,
                           input logic [3:0] exp_flags, input string what);
        @(negedge clk);
        a  = a_v;
        b  = b_v;
        op = op_v;
        @(negedge clk);   // one rising edge later the result is registered
        check_word(result, exp_word, what);
        check_flags(flags, exp_flags, what);
    endtask

    // ====================
    // directed tests
    // ====================

    task automatic test_reset(output bit ok);
        int cycles;
        a      = to_word(1.0);   // a live ADD is held so a missing reset would show
        b      = to_word(2.0);
        op     = fpu_pkg::ADD;
        arst_n = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_word(result, '0, "during reset");
            check_flags(flags, 4'b0000, "during reset");
        end
        arst_n = 1'b1;
        check_word(result, '0, "at reset release");
        check_flags(flags, 4'b0000, "at reset release");
        cycles = 0;
        while (result === '0 && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        ok = (result !== '0);
        if (ok) begin
            check_word(result, to_word(3.0), "first add after reset");
            if (cycles != 1) begin
                $display("ERR %0t: first result took %0d cycles, expected 1", $time, cycles);
                word_errors++;
            end
        end
    endtask

    task automatic test_add_sub();
        int x;
        int y;
        for (int i = 0; i < 12; i++) begin
            x = rand_int(4096);
            y = rand_int(4096);
            exec_op(to_word(real'(x)), to_word(real'(y)), fpu_pkg::ADD,
                    int_op_word(fpu_pkg::ADD, x, y), 4'b0000, $sformatf("%0d + %0d", x, y));
            exec_op(to_word(real'(x)), to_word(real'(y)), fpu_pkg::SUB,
                    int_op_word(fpu_pkg::SUB, x, y), 4'b0000, $sformatf("%0d - %0d", x, y));
        end
        exec_op(32'h3f80_0000, 32'h3380_0000, fpu_pkg::ADD, 32'h3f80_0000, 4'b0100,
                "1.0 + 2^-24");
        exec_op(32'h4060_0000, 32'h4060_0000, fpu_pkg::SUB, 32'h0000_0000, 4'b0000, "3.5 - 3.5");
        exec_op(fpu_pkg::FP_POS_INF, 32'h4040_0000, fpu_pkg::ADD, fpu_pkg::FP_POS_INF, 4'b0000,
                "+inf + 3.0");
        exec_op(fpu_pkg::FP_POS_INF, fpu_pkg::FP_POS_INF, fpu_pkg::SUB, fpu_pkg::FP_QNAN,
                4'b1000, "+inf - +inf");
        exec_op(32'h7f7f_ffff, 32'h7f7f_ffff, fpu_pkg::ADD, fpu_pkg::FP_POS_INF, 4'b0110,
                "max + max");
        // the difference 2^-149 lies below the normal range
        exec_op(32'h0080_0001, 32'h0080_0000, fpu_pkg::SUB, 32'h0000_0000, 4'b0101,
                "tiny difference");
    endtask

    task automatic test_mul();
        int x;
        int y;
        for (int i = 0; i < 12; i++) begin
            x = rand_int(2047);
            y = rand_int(2047);
            exec_op(to_word(real'(x)), to_word(real'(y)), fpu_pkg::MUL,
                    int_op_word(fpu_pkg::MUL, x, y), 4'b0000, $sformatf("%0d * %0d", x, y));
        end
        // -2^100 * 2^100 runs past the largest exponent
        exec_op(32'hf180_0000, 32'h7180_0000, fpu_pkg::MUL, fpu_pkg::FP_NEG_INF, 4'b0110,
                "-2^100 * 2^100");
        exec_op(32'h0d80_0000, 32'h0d80_0000, fpu_pkg::MUL, 32'h0000_0000, 4'b0101,
                "2^-100 * 2^-100");
        exec_op(fpu_pkg::FP_POS_INF, 32'h0000_0000, fpu_pkg::MUL, fpu_pkg::FP_QNAN, 4'b1000,
                "inf * 0");
        exec_op(fpu_pkg::FP_POS_INF, to_word(-2.0), fpu_pkg::MUL, fpu_pkg::FP_NEG_INF, 4'b0000,
                "inf * -2.0");
        exec_op(32'h3fc0_0000, 32'h3f80_0001, fpu_pkg::MUL, 32'h3fc0_0001, 4'b0100,
                "1.5 * (1 + 2^-23)");   // exact value has a 2^-24 tail that is cut
    endtask

    task automatic test_compare();
        int x;
        int y;
        for (int i = 0; i < 12; i++) begin
            x = rand_int(4096);
            y = (i % 4 == 0) ? x : rand_int(4096);   // equal pairs now and then
            exec_op(to_word(real'(x)), to_word(real'(y)), fpu_pkg::SLT,
                    int_op_word(fpu_pkg::SLT, x, y), 4'b0000, $sformatf("%0d < %0d", x, y));
        end
        exec_op(32'h8000_0000, 32'h0000_0000, fpu_pkg::SLT, 32'h0, 4'b0000, "-0 < +0");
        exec_op(32'h0000_0000, 32'h8000_0000, fpu_pkg::SLT, 32'h0, 4'b0000, "+0 < -0");
        exec_op(fpu_pkg::FP_QNAN, to_word(1.0), fpu_pkg::SLT, 32'h0, 4'b1000, "NaN < 1.0");
    endtask

    task automatic test_screening();
        exec_op(32'h7f80_0001, to_word(1.0), fpu_pkg::ADD, fpu_pkg::FP_QNAN, 4'b1000,
                "sNaN + 1.0");
        exec_op(to_word(2.0), 32'h7f80_0001, fpu_pkg::MUL, fpu_pkg::FP_QNAN, 4'b1000,
                "2.0 * sNaN");
        exec_op(32'h7f80_0001, to_word(1.0), fpu_pkg::NOP, 32'h7f80_0001, 4'b0000, "NOP sNaN");
        exec_op(to_word(-5.0), to_word(1.0), fpu_pkg::NOP, to_word(-5.0), 4'b0000, "NOP -5.0");
        exec_op(to_word(1.0), to_word(2.0), fpu_pkg::fp_op_t'(5'd19), 32'h0, 4'b0000, "code 19");
    endtask

    task automatic test_back_to_back();
        fpu_pkg::fp_op_t   ops [5];
        fpu_pkg::fp_word_t exp_word;
        int                x;
        int                y;
        ops = '{fpu_pkg::ADD, fpu_pkg::MUL, fpu_pkg::SUB, fpu_pkg::SLT, fpu_pkg::NOP};
        exp_word = '0;
        for (int i = 0; i <= 20; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_word(result, exp_word, $sformatf("back-to-back step %0d", i - 1));
                check_flags(flags, 4'b0000, $sformatf("back-to-back step %0d", i - 1));
            end
            if (i < 20) begin
                x        = rand_int(2047);
                y        = rand_int(2047);
                a        = to_word(real'(x));
                b        = to_word(real'(y));
                op       = ops[i % 5];
                exp_word = int_op_word(ops[i % 5], x, y);
            end
        end
    endtask

    // ====================
    // main flow
    // ====================

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        a      = '0;
        b      = '0;
        op     = fpu_pkg::NOP;
        void'($urandom(32'h1f5b_af83));
        test_reset(reset_ok);
        if (!reset_ok) begin
            $display("timeout: the DUT result stayed at zero after reset was released");
            $display("errors: result %0d, flags %0d", word_errors, flag_errors);
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            test_add_sub();
            test_mul();
            test_compare();
            test_screening();
            test_back_to_back();
            $display("errors: result %0d, flags %0d", word_errors, flag_errors);
            if (total_errors() == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule
